// ==== all.f ====
source/core_pkg.sv
source/reg_file.sv
source/alu.sv
source/fetch_stage.sv
source/decode_stage.sv
source/execute_stage.sv
source/mem_wb_stage.sv
source/core_top.sv
dv/tb_core_top.sv

// ==== run.sh ====
#!/bin/sh
set -e

# run from the project root so the trace path in the testbench resolves
cd "$(dirname "$0")"

verilator --binary -j 0 --top-module tb_core_top -f all.f -o tb_core_top

./obj_dir/tb_core_top

// ==== dv/core_trace.txt ====
# first value: number of program words, then one instruction word per line (hex)
# after the program: golden writebacks as pc, register number, value (hex)
1f        # program words
142468a4  # 1c000000 lu12i.w r4, 0x12345
0299e084  # 1c000004 addi.w  r4, r4, 0x678
02bffc05  # 1c000008 addi.w  r5, r0, -1
02801406  # 1c00000c addi.w  r6, r0, 5
001218a7  # 1c000010 slt     r7, r5, r6
001298a8  # 1c000014 sltu    r8, r5, r6
00111889  # 1c000018 sub.w   r9, r4, r6
0014008a  # 1c00001c nor     r10, r4, r0
0014a54b  # 1c000020 and     r11, r10, r9
0015196c  # 1c000024 or      r12, r11, r6
0015918d  # 1c000028 xor     r13, r12, r4
004090ce  # 1c00002c slli.w  r14, r6, 4
0044f0af  # 1c000030 srli.w  r15, r5, 28
0048a150  # 1c000034 srai.w  r16, r10, 8
00103dd1  # 1c000038 add.w   r17, r14, r15
29804011  # 1c00003c st.w    r17, r0, 0x10
28804012  # 1c000040 ld.w    r18, r0, 0x10
02800653  # 1c000044 addi.w  r19, r18, 1   load-use
02815400  # 1c000048 addi.w  r0, r0, 0x55
00101814  # 1c00004c add.w   r20, r0, r6
5c000a86  # 1c000050 bne     r20, r6, +8   not taken
58000e86  # 1c000054 beq     r20, r6, +12  taken
029eb415  # 1c000058 addi.w  r21, r0, 0x7ad  marker
029eb815  # 1c00005c addi.w  r21, r0, 0x7ae  marker
54001000  # 1c000060 bl      +16
02848c16  # 1c000064 addi.w  r22, r0, 0x123
50000000  # 1c000068 b       0
029ebc15  # 1c00006c addi.w  r21, r0, 0x7af  marker
02801037  # 1c000070 addi.w  r23, r1, 4
4c000020  # 1c000074 jirl    r0, r1, 0
029ec015  # 1c000078 addi.w  r21, r0, 0x7b0  marker
1c000000 04 12345000
1c000004 04 12345678
1c000008 05 ffffffff
1c00000c 06 00000005
1c000010 07 00000001
1c000014 08 00000000
1c000018 09 12345673
1c00001c 0a edcba987
1c000020 0b 00000003
1c000024 0c 00000007
1c000028 0d 1234567f
1c00002c 0e 00000050
1c000030 0f 0000000f
1c000034 10 ffedcba9
1c000038 11 0000005f
1c000040 12 0000005f
1c000044 13 00000060
1c00004c 14 00000005
1c000060 01 1c000064
1c000070 17 1c000068
1c000064 16 00000123

// ==== dv/tb_core_top.sv ====
module tb_core_top;

    localparam int    clk_half       = 4;
    localparam int    drive_delay    = 1;
    localparam int    reset_cycles   = 4;
    localparam int    timeout_cycles = 2000;
    localparam int    drain_cycles   = 8;
    localparam int    imem_words     = 64;
    localparam int    dmem_words     = 256;
    localparam int    record_fields  = 3;   // pc, register number, value
    localparam string trace_path     = "dv/core_trace.txt";

    logic        clk;
    logic        resetn;
    logic [31:0] inst_rdata;
    logic [31:0] data_rdata;
    logic [31:0] inst_addr;
    logic        data_we;
    logic [31:0] data_addr;
    logic [31:0] data_wdata;
    logic [31:0] data_raddr;
    logic [31:0] debug_wb_pc;
    logic        debug_wb_rf_we;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;

    logic [31:0] imem [0:imem_words-1];
    logic [31:0] dmem [0:dmem_words-1];
    logic [31:0] imem_index;
    logic [31:0] gold_pc [$];
    logic [31:0] gold_reg [$];
    logic [31:0] gold_data [$];
    int          retired = 0;

    core_top uut (
        .clk               (clk),
        .resetn            (resetn),
        .inst_rdata        (inst_rdata),
        .data_rdata        (data_rdata),
        .inst_addr         (inst_addr),
        .data_we           (data_we),
        .data_addr         (data_addr),
        .data_wdata        (data_wdata),
        .data_raddr        (data_raddr),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    initial begin
        clk = 1'b0;
        forever #clk_half clk = ~clk;
    end

    // instruction memory reads zero outside the program
    assign imem_index = (inst_addr - core_pkg::reset_pc) >> 2;
    assign inst_rdata = (imem_index < imem_words) ? imem[imem_index[5:0]] : 32'h0;

    // data memory reads asynchronously and writes on the edge
    assign data_rdata = dmem[data_raddr[9:2]];

    initial begin
        for (int i = 0; i < dmem_words; i++) begin
            dmem[i[7:0]] <= 32'h0;
        end
    end

    always @(posedge clk) begin
        if (data_we) begin
            dmem[data_addr[9:2]] <= data_wdata;
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[FAIL] %s expected %h actual %h", name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "writeback does not match the golden trace");
        end
    endtask

    task automatic load_trace();
        int          fd;
        int          n_fields;
        int          n_words;
        int          loaded;
        logic [31:0] f0, f1, f2;
        string       line;
        fd = $fopen(trace_path, "r");
        if (fd == 0) begin
            $display("Simulation failed");
            $fatal(1, "the trace file %s could not be opened", trace_path);
        end
        for (int i = 0; i < imem_words; i++) begin
            imem[i[5:0]] = 32'h0;
        end
        n_words = -1;
        loaded  = 0;
        while ($fgets(line, fd) != 0) begin
            n_fields = $sscanf(line, "%h %h %h", f0, f1, f2);
            if (n_fields <= 0) begin
                // comment or blank line
            end else if (n_words < 0) begin
                n_words = f0;
            end else if (loaded < n_words) begin
                imem[loaded[5:0]] = f0;
                loaded++;
            end else if (n_fields == record_fields) begin
                gold_pc.push_back(f0);
                gold_reg.push_back(f1);
                gold_data.push_back(f2);
            end
        end
        $fclose(fd);
        if (n_words > imem_words || loaded != n_words || gold_pc.size() == 0) begin
            $display("Simulation failed");
            $fatal(1, "the trace file holds no usable program and golden records");
        end
    endtask

    // sampled at the falling edge where the writeback ports are stable
    always @(negedge clk) begin
        if (resetn && debug_wb_rf_we && debug_wb_rf_wnum != 5'd0) begin
            if (retired >= gold_pc.size()) begin
                $display("Simulation failed");
                $fatal(1, "the core wrote register %0d after the trace ended",
                       debug_wb_rf_wnum);
            end else begin
                check_value($sformatf("record %0d pc", retired), gold_pc[retired],
                            debug_wb_pc);
                check_value($sformatf("record %0d register", retired), gold_reg[retired],
                            {27'd0, debug_wb_rf_wnum});
                check_value($sformatf("record %0d value", retired), gold_data[retired],
                            debug_wb_rf_wdata);
                retired++;
            end
        end
    end

    initial begin
        int cycles;
        resetn = 1'b0;
        load_trace();
        repeat (reset_cycles) @(posedge clk);
        #drive_delay resetn = 1'b1;

        cycles = 0;
        while (retired < gold_pc.size() && cycles < timeout_cycles) begin
            @(posedge clk);
            cycles++;
        end

        if (retired == gold_pc.size()) begin
            // the final self-loop must not write anything more
            repeat (drain_cycles) @(posedge clk);
            $display("Simulation completed successfully");
            $finish;
        end else begin
            $display("Simulation failed");
            $fatal(1, "the core stopped retiring after %0d of %0d trace records",
                   retired, gold_pc.size());
        end
    end

endmodule

// ==== source/core_top.sv ====
module core_top (
    input  logic        clk,
    input  logic        resetn,
    input  logic [31:0] inst_rdata,
    input  logic [31:0] data_rdata,
    output logic [31:0] inst_addr,
    output logic        data_we,
    output logic [31:0] data_addr,
    output logic [31:0] data_wdata,
    output logic [31:0] data_raddr,
    output logic [31:0] debug_wb_pc,
    output logic        debug_wb_rf_we,
    output logic [4:0]  debug_wb_rf_wnum,
    output logic [31:0] debug_wb_rf_wdata
);

    logic                                ds_allowin, es_allowin, ms_allowin;
    logic                                fs_to_ds_valid, ds_to_es_valid, es_to_ms_valid;
    logic [core_pkg::fs_to_ds_bus_w-1:0] fs_to_ds_bus;
    logic [core_pkg::br_bus_w-1:0]       br_bus;
    logic [core_pkg::ds_to_es_bus_w-1:0] ds_to_es_bus;
    logic [core_pkg::es_to_ms_bus_w-1:0] es_to_ms_bus;
    logic [core_pkg::es_fwd_bus_w-1:0]   es_fwd_bus;
    logic [core_pkg::ms_fwd_bus_w-1:0]   ms_fwd_bus;

    fetch_stage u_fetch (
        .clk            (clk),
        .resetn         (resetn),
        .ds_allowin     (ds_allowin),
        .br_bus         (br_bus),
        .inst_rdata     (inst_rdata),
        .inst_addr      (inst_addr),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_to_ds_bus   (fs_to_ds_bus)
    );

    decode_stage u_decode (
        .clk            (clk),
        .resetn         (resetn),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_to_ds_bus   (fs_to_ds_bus),
        .es_allowin     (es_allowin),
        .es_fwd_bus     (es_fwd_bus),
        .ms_fwd_bus     (ms_fwd_bus),
        .ds_allowin     (ds_allowin),
        .br_bus         (br_bus),
        .ds_to_es_valid (ds_to_es_valid),
        .ds_to_es_bus   (ds_to_es_bus)
    );

    execute_stage u_execute (
        .clk            (clk),
        .resetn         (resetn),
        .ds_to_es_valid (ds_to_es_valid),
        .ds_to_es_bus   (ds_to_es_bus),
        .ms_allowin     (ms_allowin),
        .es_allowin     (es_allowin),
        .es_to_ms_valid (es_to_ms_valid),
        .es_to_ms_bus   (es_to_ms_bus),
        .es_fwd_bus     (es_fwd_bus),
        .data_we        (data_we),
        .data_addr      (data_addr),
        .data_wdata     (data_wdata)
    );

    // register write reaches the decode register file through ms_fwd_bus
    mem_wb_stage u_mem_wb (
        .clk               (clk),
        .resetn            (resetn),
        .es_to_ms_valid    (es_to_ms_valid),
        .es_to_ms_bus      (es_to_ms_bus),
        .data_rdata        (data_rdata),
        .ms_allowin        (ms_allowin),
        .data_raddr        (data_raddr),
        .ms_fwd_bus        (ms_fwd_bus),
        .rf_we             (),
        .rf_waddr          (),
        .rf_wdata          (),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

endmodule

// ==== source/mem_wb_stage.sv ====
module mem_wb_stage (
    input  logic                                clk,
    input  logic                                resetn,
    input  logic                                es_to_ms_valid,
    input  logic [core_pkg::es_to_ms_bus_w-1:0] es_to_ms_bus,
    input  logic [31:0]                         data_rdata,
    output logic                                ms_allowin,
    output logic [31:0]                         data_raddr,
    output logic [core_pkg::ms_fwd_bus_w-1:0]   ms_fwd_bus,
    output logic                                rf_we,
    output logic [4:0]                          rf_waddr,
    output logic [31:0]                         rf_wdata,
    output logic [31:0]                         debug_wb_pc,
    output logic                                debug_wb_rf_we,
    output logic [4:0]                          debug_wb_rf_wnum,
    output logic [31:0]                         debug_wb_rf_wdata
);

    logic        ms_valid;
    logic        ms_res_from_mem;
    logic        ms_rf_we;
    logic [4:0]  ms_rf_waddr;
    logic [31:0] ms_alu_result;
    logic [31:0] ms_pc;

    assign ms_allowin = 1'b1;   // retires every cycle, nothing behind it

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ms_valid <= 1'b0;
        end else begin
            ms_valid <= es_to_ms_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (es_to_ms_valid) begin
            {ms_res_from_mem, ms_rf_we, ms_rf_waddr, ms_alu_result, ms_pc} <= es_to_ms_bus;
        end
    end

    assign data_raddr = ms_alu_result;   // load address registered from execute

    assign rf_we      = ms_rf_we & ms_valid;
    assign rf_waddr   = ms_rf_waddr;
    assign rf_wdata   = ms_res_from_mem ? data_rdata : ms_alu_result;
    assign ms_fwd_bus = {rf_we, rf_waddr, rf_wdata};

    assign debug_wb_pc       = ms_pc;
    assign debug_wb_rf_we    = rf_we;
    assign debug_wb_rf_wnum  = rf_waddr;
    assign debug_wb_rf_wdata = rf_wdata;

endmodule

// ==== source/execute_stage.sv ====
module execute_stage (
    input  logic                                clk,
    input  logic                                resetn,
    input  logic                                ds_to_es_valid,
    input  logic [core_pkg::ds_to_es_bus_w-1:0] ds_to_es_bus,
    input  logic                                ms_allowin,
    output logic                                es_allowin,
    output logic                                es_to_ms_valid,
    output logic [core_pkg::es_to_ms_bus_w-1:0] es_to_ms_bus,
    output logic [core_pkg::es_fwd_bus_w-1:0]   es_fwd_bus,
    output logic                                data_we,
    output logic [31:0]                         data_addr,
    output logic [31:0]                         data_wdata
);

    logic                                es_valid;
    logic [core_pkg::ds_to_es_bus_w-1:0] es_bus;
    logic [core_pkg::alu_op_w-1:0]       es_alu_op;
    logic                                es_res_from_mem, es_mem_we, es_rf_we;
    logic [4:0]                          es_rf_waddr;
    logic [31:0]                         es_src1, es_src2, es_st_data, es_pc, es_alu_result;

    assign es_allowin     = ~es_valid | ms_allowin;
    assign es_to_ms_valid = es_valid;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            es_valid <= 1'b0;
        end else if (es_allowin) begin
            es_valid <= ds_to_es_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ds_to_es_valid && es_allowin) begin
            es_bus <= ds_to_es_bus;
        end
    end

    assign {es_alu_op, es_res_from_mem, es_src1, es_src2, es_mem_we,
            es_rf_we, es_rf_waddr, es_st_data, es_pc} = es_bus;

    alu u_alu (
        .alu_op (es_alu_op),
        .src1   (es_src1),
        .src2   (es_src2),
        .result (es_alu_result)
    );

    // write lands on the edge that hands the store on
    assign data_we    = es_valid & es_mem_we & ms_allowin;
    assign data_addr  = es_alu_result;
    assign data_wdata = es_st_data;

    assign es_to_ms_bus = {es_res_from_mem, es_rf_we, es_rf_waddr, es_alu_result, es_pc};
    assign es_fwd_bus   = {es_res_from_mem & es_valid, es_rf_we & es_valid,
                           es_rf_waddr, es_alu_result};

endmodule

// ==== source/decode_stage.sv ====
module decode_stage (
    input  logic                                clk,
    input  logic                                resetn,
    input  logic                                fs_to_ds_valid,
    input  logic [core_pkg::fs_to_ds_bus_w-1:0] fs_to_ds_bus,
    input  logic                                es_allowin,
    input  logic [core_pkg::es_fwd_bus_w-1:0]   es_fwd_bus,
    input  logic [core_pkg::ms_fwd_bus_w-1:0]   ms_fwd_bus,
    output logic                                ds_allowin,
    output logic [core_pkg::br_bus_w-1:0]       br_bus,
    output logic                                ds_to_es_valid,
    output logic [core_pkg::ds_to_es_bus_w-1:0] ds_to_es_bus
);

    logic        ds_valid, ds_ready_go, stall;
    logic [31:0] ds_inst, ds_pc;
    logic [16:0] op17;
    logic [4:0]  rd, rj, rk;
    logic [11:0] i12;
    logic [15:0] i16;
    logic [19:0] i20;
    logic [25:0] i26;
    logic inst_add_w, inst_sub_w, inst_slt, inst_sltu, inst_nor, inst_and, inst_or, inst_xor;
    logic inst_slli_w, inst_srli_w, inst_srai_w, inst_addi_w, inst_ld_w, inst_st_w;
    logic inst_jirl, inst_b, inst_bl, inst_beq, inst_bne, inst_lu12i_w;
    logic [core_pkg::alu_op_w-1:0] alu_op;
    logic        need_si26, src2_is_4, src1_is_pc, src2_is_imm, need_r1, need_r2;
    logic        rf_we, br_taken;
    logic [4:0]  dest, raddr1, raddr2;
    logic [31:0] imm, br_offs, br_target, rdata1, rdata2, rj_value, rkd_value;
    logic        es_res_from_mem, es_we, ms_we;
    logic [4:0]  es_waddr, ms_waddr;
    logic [31:0] es_wdata, ms_wdata;
    logic        r1_es, r2_es, r1_ms, r2_ms;

    assign ds_ready_go    = ~stall;
    assign ds_allowin     = ~ds_valid | ds_ready_go & es_allowin;
    assign ds_to_es_valid = ds_valid & ds_ready_go;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ds_valid <= 1'b0;
        end else if (br_taken) begin
            ds_valid <= 1'b0;   // drop the wrong-path fetch
        end else if (ds_allowin) begin
            ds_valid <= fs_to_ds_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fs_to_ds_valid && ds_allowin) begin
            {ds_inst, ds_pc} <= fs_to_ds_bus;
        end
    end

    assign op17 = ds_inst[31:15];
    assign rd   = ds_inst[4:0];
    assign rj   = ds_inst[9:5];
    assign rk   = ds_inst[14:10];
    assign i12  = ds_inst[21:10];
    assign i16  = ds_inst[25:10];
    assign i20  = ds_inst[24:5];
    assign i26  = {ds_inst[9:0], ds_inst[25:10]};

    // 3R format and shift-by-ui5 opcodes
    assign inst_add_w   = op17 == 17'h00020;
    assign inst_sub_w   = op17 == 17'h00022;
    assign inst_slt     = op17 == 17'h00024;
    assign inst_sltu    = op17 == 17'h00025;
    assign inst_nor     = op17 == 17'h00028;
    assign inst_and     = op17 == 17'h00029;
    assign inst_or      = op17 == 17'h0002a;
    assign inst_xor     = op17 == 17'h0002b;
    assign inst_slli_w  = op17 == 17'h00081;
    assign inst_srli_w  = op17 == 17'h00089;
    assign inst_srai_w  = op17 == 17'h00091;
    assign inst_addi_w  = ds_inst[31:22] == 10'h00a;
    assign inst_ld_w    = ds_inst[31:22] == 10'h0a2;
    assign inst_st_w    = ds_inst[31:22] == 10'h0a6;
    assign inst_jirl    = ds_inst[31:26] == 6'h13;
    assign inst_b       = ds_inst[31:26] == 6'h14;
    assign inst_bl      = ds_inst[31:26] == 6'h15;
    assign inst_beq     = ds_inst[31:26] == 6'h16;
    assign inst_bne     = ds_inst[31:26] == 6'h17;
    assign inst_lu12i_w = ds_inst[31:26] == 6'h05 && !ds_inst[25];

    // b, beq and bne leave the alu idle
    assign alu_op[core_pkg::alu_add]  = inst_add_w | inst_addi_w | inst_ld_w | inst_st_w
                                      | inst_jirl | inst_bl;
    assign alu_op[core_pkg::alu_sub]  = inst_sub_w;
    assign alu_op[core_pkg::alu_slt]  = inst_slt;
    assign alu_op[core_pkg::alu_sltu] = inst_sltu;
    assign alu_op[core_pkg::alu_and]  = inst_and;
    assign alu_op[core_pkg::alu_nor]  = inst_nor;
    assign alu_op[core_pkg::alu_or]   = inst_or;
    assign alu_op[core_pkg::alu_xor]  = inst_xor;
    assign alu_op[core_pkg::alu_sll]  = inst_slli_w;
    assign alu_op[core_pkg::alu_srl]  = inst_srli_w;
    assign alu_op[core_pkg::alu_sra]  = inst_srai_w;
    assign alu_op[core_pkg::alu_lui]  = inst_lu12i_w;

    assign need_si26   = inst_b | inst_bl;
    assign src2_is_4   = inst_jirl | inst_bl;   // link value is pc + 4
    assign src1_is_pc  = inst_jirl | inst_bl;
    assign src2_is_imm = inst_slli_w | inst_srli_w | inst_srai_w | inst_addi_w | inst_ld_w
                       | inst_st_w | inst_lu12i_w | inst_jirl | inst_bl;

    // ui5 sits in the low bits of the si12 field
    assign imm = src2_is_4    ? 32'd4 :
                 inst_lu12i_w ? {i20, 12'b0} : {{20{i12[11]}}, i12};

    assign br_offs   = need_si26 ? {{4{i26[25]}}, i26, 2'b0} : {{14{i16[15]}}, i16, 2'b0};
    assign br_target = (inst_jirl ? rj_value : ds_pc) + br_offs;
    assign br_taken  = (inst_beq && rj_value == rkd_value || inst_bne && rj_value != rkd_value
                       || inst_jirl || inst_b || inst_bl) && ds_valid && ds_ready_go;
    assign br_bus    = {br_taken, br_target};

    assign raddr1 = rj;
    assign raddr2 = (inst_beq | inst_bne | inst_st_w) ? rd : rk;
    assign rf_we  = ~inst_st_w & ~inst_beq & ~inst_bne & ~inst_b;
    assign dest   = inst_bl ? 5'd1 : rd;

    reg_file u_reg_file (
        .clk    (clk),
        .raddr1 (raddr1),
        .raddr2 (raddr2),
        .we     (ms_we),
        .waddr  (ms_waddr),
        .wdata  (ms_wdata),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    assign {es_res_from_mem, es_we, es_waddr, es_wdata} = es_fwd_bus;
    assign {ms_we, ms_waddr, ms_wdata}                  = ms_fwd_bus;

    // r0 never matches
    assign r1_es = (|raddr1) && raddr1 == es_waddr && es_we;
    assign r2_es = (|raddr2) && raddr2 == es_waddr && es_we;
    assign r1_ms = (|raddr1) && raddr1 == ms_waddr && ms_we;
    assign r2_ms = (|raddr2) && raddr2 == ms_waddr && ms_we;

    assign need_r1 = ~inst_b & ~inst_bl & ~inst_lu12i_w;
    assign need_r2 = inst_add_w | inst_sub_w | inst_slt | inst_sltu | inst_and | inst_or
                   | inst_nor | inst_xor | inst_beq | inst_bne | inst_st_w;
    // load data only exists one stage later
    assign stall = es_res_from_mem & (r1_es & need_r1 | r2_es & need_r2);

    assign rj_value  = r1_es ? es_wdata : r1_ms ? ms_wdata : rdata1;
    assign rkd_value = r2_es ? es_wdata : r2_ms ? ms_wdata : rdata2;

    assign ds_to_es_bus = {alu_op,
                           inst_ld_w,
                           src1_is_pc ? ds_pc : rj_value,
                           src2_is_imm ? imm : rkd_value,
                           inst_st_w,
                           rf_we,
                           dest,
                           rkd_value,   // store data
                           ds_pc};

endmodule

// ==== source/fetch_stage.sv ====
module fetch_stage (
    input  logic                              clk,
    input  logic                              resetn,
    input  logic                              ds_allowin,
    input  logic [core_pkg::br_bus_w-1:0]     br_bus,
    input  logic [31:0]                       inst_rdata,
    output logic [31:0]                       inst_addr,
    output logic                              fs_to_ds_valid,
    output logic [core_pkg::fs_to_ds_bus_w-1:0] fs_to_ds_bus
);

    logic        fs_valid;
    logic        fs_allowin;
    logic [31:0] fs_pc;
    logic        br_taken;
    logic [31:0] br_target;

    assign {br_taken, br_target} = br_bus;
    assign fs_allowin = ~fs_valid | ds_allowin;   // ready_go is always high

    // becomes valid on the first edge out of reset and stays there
    always_ff @(posedge clk) begin
        if (!resetn) begin
            fs_valid <= 1'b0;
        end else begin
            fs_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            fs_pc <= core_pkg::reset_pc - 32'd4;  // first advance lands on reset_pc
        end else if (br_taken) begin
            fs_pc <= br_target;
        end else if (fs_allowin) begin
            fs_pc <= fs_pc + 32'd4;
        end
    end

    assign inst_addr      = fs_pc;
    assign fs_to_ds_valid = fs_valid;
    assign fs_to_ds_bus   = {inst_rdata, fs_pc};

endmodule

// ==== source/alu.sv ====
module alu (
    input  logic [core_pkg::alu_op_w-1:0] alu_op,
    input  logic [31:0]                   src1,
    input  logic [31:0]                   src2,
    output logic [31:0]                   result
);

    logic        sub_like;
    logic [31:0] adder_b;
    logic [32:0] adder_sum;
    logic        slt_res;
    logic        sltu_res;
    logic [31:0] sll_res;
    logic [31:0] srl_res;
    logic [31:0] sra_res;

    // sub, slt and sltu all compute src1 - src2
    assign sub_like  = alu_op[core_pkg::alu_sub] | alu_op[core_pkg::alu_slt]
                     | alu_op[core_pkg::alu_sltu];
    assign adder_b   = sub_like ? ~src2 : src2;
    assign adder_sum = {1'b0, src1} + {1'b0, adder_b} + {32'd0, sub_like};

    assign slt_res  = (src1[31] & ~src2[31]) | (~(src1[31] ^ src2[31]) & adder_sum[31]);
    assign sltu_res = ~adder_sum[32];   // no carry out means borrow

    assign sll_res = src1 << src2[4:0];
    assign srl_res = src1 >> src2[4:0];
    assign sra_res = $signed(src1) >>> src2[4:0];

    assign result = ({32{alu_op[core_pkg::alu_add] | alu_op[core_pkg::alu_sub]}} & adder_sum[31:0])
                  | ({32{alu_op[core_pkg::alu_slt]}}  & {31'd0, slt_res})
                  | ({32{alu_op[core_pkg::alu_sltu]}} & {31'd0, sltu_res})
                  | ({32{alu_op[core_pkg::alu_and]}}  & (src1 & src2))
                  | ({32{alu_op[core_pkg::alu_nor]}}  & ~(src1 | src2))
                  | ({32{alu_op[core_pkg::alu_or]}}   & (src1 | src2))
                  | ({32{alu_op[core_pkg::alu_xor]}}  & (src1 ^ src2))
                  | ({32{alu_op[core_pkg::alu_sll]}}  & sll_res)
                  | ({32{alu_op[core_pkg::alu_srl]}}  & srl_res)
                  | ({32{alu_op[core_pkg::alu_sra]}}  & sra_res)
                  | ({32{alu_op[core_pkg::alu_lui]}}  & src2);   // imm already shifted

endmodule

// ==== source/reg_file.sv ====
module reg_file (
    input  logic        clk,
    input  logic [4:0]  raddr1,
    input  logic [4:0]  raddr2,
    input  logic        we,
    input  logic [4:0]  waddr,
    input  logic [31:0] wdata,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2
);

    logic [31:0] rf [31:0];

    always_ff @(posedge clk) begin
        if (we) begin
            rf[waddr] <= wdata;
        end
    end

    // r0 reads zero whatever was written to it
    assign rdata1 = (raddr1 == 5'd0) ? 32'd0 : rf[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? 32'd0 : rf[raddr2];

endmodule

// ==== source/core_pkg.sv ====
package core_pkg;

    localparam logic [31:0] reset_pc = 32'h1c000000;

    // bus widths between stages
    localparam int fs_to_ds_bus_w = 64;   // {inst, pc}
    localparam int br_bus_w       = 33;   // {br_taken, br_target}
    localparam int ds_to_es_bus_w = 148;
    localparam int es_to_ms_bus_w = 71;
    localparam int es_fwd_bus_w   = 39;   // {res_from_mem, we, waddr, data}
    localparam int ms_fwd_bus_w   = 38;   // {we, waddr, data}

    // one-hot alu operation bits
    localparam int alu_op_w = 12;
    localparam int alu_add  = 0;
    localparam int alu_sub  = 1;
    localparam int alu_slt  = 2;
    localparam int alu_sltu = 3;
    localparam int alu_and  = 4;
    localparam int alu_nor  = 5;
    localparam int alu_or   = 6;
    localparam int alu_xor  = 7;
    localparam int alu_sll  = 8;
    localparam int alu_srl  = 9;
    localparam int alu_sra  = 10;
    localparam int alu_lui  = 11;

endpackage
